// ==== filelist.f ====
src/rv_core_pkg.sv
src/id_ex_if.sv
src/ex_wb_if.sv
src/rv_decode.sv
src/id_ex_reg.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_pipe_top.sv
verification/tb_rv_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs tb_rv_pipe with Verilator
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_pipe \
    -f filelist.f -o tb_rv_pipe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rv_pipe | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation ended with an error status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    exit 1
fi
exit 0

// ==== src/ex_wb_if.sv ====
`timescale 1ns/1ps

interface ex_wb_if import rv_core_pkg::*; ();
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  we;
    logic [XLEN-1:0]       data;
    logic [XLEN-1:0]       pc;
    logic                  redirect;  // taken branch or jump
    logic [XLEN-1:0]       target;
    logic                  illegal;

    modport src (
        output valid, rd, we, data, pc, redirect, target, illegal
    );
    modport dst (
        input valid, rd, we, data, pc, redirect, target, illegal
    );
endinterface

// ==== src/id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if import rv_core_pkg::*; ();
    logic                  valid;
    alu_op_e               alu_op;
    sel_a_e                sel_a;
    sel_b_e                sel_b;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  write_rd;
    ctrl_e                 ctrl;
    logic [2:0]            br_funct;  // funct3 of a branch
    logic                  illegal;

    modport dec (
        output valid, alu_op, sel_a, sel_b, imm, pc, rs1, rs2, rd, write_rd, ctrl,
               br_funct, illegal
    );
    modport reg_in (
        input valid, alu_op, sel_a, sel_b, imm, pc, rs1, rs2, rd, write_rd, ctrl,
              br_funct, illegal
    );
    modport reg_out (
        output valid, alu_op, sel_a, sel_b, imm, pc, rs1, rs2, rd, write_rd, ctrl,
               br_funct, illegal
    );
    modport exe (
        input valid, alu_op, sel_a, sel_b, imm, pc, rs1, rs2, rd, write_rd, ctrl,
              br_funct, illegal
    );
endinterface

// ==== src/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg import rv_core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    bubble_i,  // stall, hold contents
    input  logic    flush_i,   // redirect, load a bubble
    id_ex_if.reg_in  d_i,
    id_ex_if.reg_out q_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            q_o.valid    <= 1'b0;
            q_o.alu_op   <= ADD;
            q_o.sel_a    <= SEL_A_RS1;
            q_o.sel_b    <= SEL_B_RS2;
            q_o.imm      <= '0;
            q_o.pc       <= '0;
            q_o.rs1      <= '0;
            q_o.rs2      <= '0;
            q_o.rd       <= '0;
            q_o.write_rd <= 1'b0;
            q_o.ctrl     <= CTRL_NONE;
            q_o.br_funct <= '0;
            q_o.illegal  <= 1'b0;
        end else if (!bubble_i) begin
            q_o.valid    <= d_i.valid;
            q_o.alu_op   <= d_i.alu_op;
            q_o.sel_a    <= d_i.sel_a;
            q_o.sel_b    <= d_i.sel_b;
            q_o.imm      <= d_i.imm;
            q_o.pc       <= d_i.pc;
            q_o.rs1      <= d_i.rs1;
            q_o.rs2      <= d_i.rs2;
            q_o.rd       <= d_i.rd;
            q_o.write_rd <= d_i.write_rd;
            q_o.ctrl     <= d_i.ctrl;
            q_o.br_funct <= d_i.br_funct;
            q_o.illegal  <= d_i.illegal;
        end
    end

    // execute masks flush while stalled
    a_no_flush_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n_i) !(flush_i && bubble_i)
    ) else $error("id_ex_reg: flush during stall");

endmodule

// ==== src/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int PC_STEP    = 4;  // fixed 32-bit instructions

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A_RS1  = 2'd0,
        SEL_A_PC   = 2'd1,
        SEL_A_ZERO = 2'd2
    } sel_a_e;

    typedef enum logic {
        SEL_B_RS2 = 1'b0,
        SEL_B_IMM = 1'b1
    } sel_b_e;

    typedef enum logic [1:0] {
        CTRL_NONE   = 2'd0,
        CTRL_BRANCH = 2'd1,
        CTRL_JAL    = 2'd2,
        CTRL_JALR   = 2'd3
    } ctrl_e;

    // branch kinds as carried in br_funct
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

// ==== src/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_core_pkg::*; (
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    id_ex_if.dec            id_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            alt;       // funct7[5], sub/sra select
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_b;

    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub_sra);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_sra ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = sub_sra ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_b = {{51{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    always_comb begin
        id_o.valid    = instr_valid_i;
        id_o.pc       = pc_i;
        id_o.rs1      = instr_i[19:15];
        id_o.rs2      = instr_i[24:20];
        id_o.rd       = instr_i[11:7];
        id_o.br_funct = funct3;
        id_o.alu_op   = PASS_B;
        id_o.sel_a    = SEL_A_ZERO;
        id_o.sel_b    = SEL_B_IMM;
        id_o.imm      = '0;
        id_o.write_rd = 1'b1;
        id_o.ctrl     = CTRL_NONE;
        id_o.illegal  = 1'b0;
        case (opcode)
            OP: begin
                id_o.alu_op = f3_to_alu(funct3, alt);
                id_o.sel_a  = SEL_A_RS1;
                id_o.sel_b  = SEL_B_RS2;
            end
            OP_IMM: begin
                // bit 30 is an immediate bit except for srai
                id_o.alu_op = f3_to_alu(funct3, alt && (funct3 == 3'b101));
                id_o.sel_a  = SEL_A_RS1;
                id_o.imm    = imm_i;
            end
            LUI: begin
                id_o.alu_op = ADD;
                id_o.imm    = imm_u;
            end
            AUIPC: begin
                id_o.alu_op = ADD;
                id_o.sel_a  = SEL_A_PC;
                id_o.imm    = imm_u;
            end
            JAL: begin
                id_o.alu_op = ADD;  // alu forms the target
                id_o.sel_a  = SEL_A_PC;
                id_o.imm    = imm_j;
                id_o.ctrl   = CTRL_JAL;
            end
            JALR: begin
                id_o.alu_op = ADD;
                id_o.sel_a  = SEL_A_RS1;
                id_o.imm    = imm_i;
                id_o.ctrl   = CTRL_JALR;
            end
            BRANCH: begin
                id_o.alu_op   = ADD;
                id_o.sel_a    = SEL_A_PC;
                id_o.imm      = imm_b;
                id_o.ctrl     = CTRL_BRANCH;
                id_o.write_rd = 1'b0;
            end
            default: begin
                id_o.illegal  = 1'b1;
                id_o.write_rd = 1'b0;
            end
        endcase
    end

    always_comb begin
        assert (!(id_o.illegal && id_o.write_rd))
            else $error("rv_decode: illegal instruction marked as writing rd");
    end

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    id_ex_if.exe                  ex_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  flush_o,
    ex_wb_if.src                  res_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic            cond;
    logic            taken;
    logic            is_jump;

    assign rs1_addr_o = ex_i.rs1;
    assign rs2_addr_o = ex_i.rs2;

    always_comb begin
        case (ex_i.sel_a)
            SEL_A_RS1: op_a = rs1_data_i;
            SEL_A_PC:  op_a = ex_i.pc;
            default:   op_a = '0;
        endcase
    end

    assign op_b  = (ex_i.sel_b == SEL_B_IMM) ? ex_i.imm : rs2_data_i;
    assign shamt = op_b[5:0];

    always_comb begin
        case (ex_i.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLL:     alu_res = op_a << shamt;
            SLT:     alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_res = {63'b0, op_a < op_b};
            XOR:     alu_res = op_a ^ op_b;
            SRL:     alu_res = op_a >> shamt;
            SRA:     alu_res = $unsigned($signed(op_a) >>> shamt);
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            default: alu_res = op_b;  // PASS_B
        endcase
    end

    // compare on the register values since the alu forms the target
    always_comb begin
        case (ex_i.br_funct)
            F3_BEQ:  cond = (rs1_data_i == rs2_data_i);
            F3_BNE:  cond = (rs1_data_i != rs2_data_i);
            F3_BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
            F3_BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            F3_BLTU: cond = (rs1_data_i < rs2_data_i);
            F3_BGEU: cond = (rs1_data_i >= rs2_data_i);
            default: cond = 1'b0;
        endcase
    end

    assign is_jump = (ex_i.ctrl == CTRL_JAL) || (ex_i.ctrl == CTRL_JALR);
    assign taken   = is_jump || ((ex_i.ctrl == CTRL_BRANCH) && cond);
    assign flush_o = ex_i.valid && !stall_i && taken;

    assign res_o.valid    = ex_i.valid;
    assign res_o.rd       = ex_i.rd;
    assign res_o.we       = ex_i.write_rd;
    assign res_o.data     = is_jump ? ex_i.pc + XLEN'(PC_STEP) : alu_res;  // link value
    assign res_o.pc       = ex_i.pc;
    assign res_o.redirect = taken;
    assign res_o.target   = (ex_i.ctrl == CTRL_JALR) ? {alu_res[XLEN-1:1], 1'b0} : alu_res;
    assign res_o.illegal  = ex_i.illegal;

    // the slot behind a redirect comes back as a bubble
    a_flush_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n_i) flush_o |-> ex_i.valid ##1 !ex_i.valid
    ) else $error("rv_execute: flush without a valid instruction or not followed by a bubble");

endmodule

// ==== src/rv_pipe_top.sv ====
`timescale 1ns/1ps

module rv_pipe_top import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic                  illegal_o
);

    logic                  flush;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs2_data;

    id_ex_if id_d ();  // decoder side
    id_ex_if id_q ();  // execute side
    ex_wb_if ex_wb ();

    rv_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .id_o          (id_d.dec)
    );

    id_ex_reg u_id_ex (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .bubble_i (stall_i),
        .flush_i  (flush),
        .d_i      (id_d.reg_in),
        .q_o      (id_q.reg_out)
    );

    rv_execute u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .ex_i       (id_q.exe),
        .rs1_addr_o (rs1_addr),
        .rs1_data_i (rs1_data),
        .rs2_addr_o (rs2_addr),
        .rs2_data_i (rs2_data),
        .flush_o    (flush),
        .res_o      (ex_wb.src)
    );

    rv_result u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .res_i         (ex_wb.dst),
        .rs1_addr_i    (rs1_addr),
        .rs1_data_o    (rs1_data),
        .rs2_addr_i    (rs2_addr),
        .rs2_data_o    (rs2_data),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .illegal_o     (illegal_o)
    );

endmodule

// ==== src/rv_result.sv ====
`timescale 1ns/1ps

module rv_result import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,
    ex_wb_if.dst                  res_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs2_data_o,
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o,
    output logic [XLEN-1:0]       wb_pc_o,
    output logic                  redirect_o,
    output logic [XLEN-1:0]       redirect_pc_o,
    output logic                  illegal_o
);

    logic [XLEN-1:0] regs [1:31];  // x0 not stored
    logic            retire;
    logic            wr_en;

    assign retire = res_i.valid && !stall_i;
    assign wr_en  = retire && res_i.we && (res_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_i.rd] <= res_i.data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            redirect_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            wb_valid_o <= retire;
            redirect_o <= retire && res_i.redirect;
            illegal_o  <= retire && res_i.illegal;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o       <= res_i.rd;
        wb_data_o     <= wr_en ? res_i.data : '0;  // zero when nothing written
        wb_pc_o       <= res_i.pc;
        redirect_pc_o <= res_i.target;
    end

    // the last write reads back on the next cycle and x0 stays zero
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (retire && res_i.we) |=>
            (rs1_addr_i != $past(res_i.rd)) ||
            (rs1_data_o == (($past(res_i.rd) == '0) ? '0 : $past(res_i.data)))
    ) else $error("rv_result: register read back does not match the last write");

endmodule

// ==== verification/tb_rv_pipe.sv ====
`timescale 1ns/1ps

module tb_rv_pipe import rv_core_pkg::*; ();

    localparam int N_INSTR    = 600;
    localparam int MAX_CYCLES = N_INSTR * 5;  // 1 cycle per instr, up to 3 of stall, drain

    typedef struct packed {
        logic [4:0]      rd;
        logic            we;
        logic [XLEN-1:0] data;
        logic [XLEN-1:0] pc;
        logic            redir;
        logic [XLEN-1:0] tgt;
        logic            ill;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic stall;
    logic instr_valid;
    logic [31:0] instr;
    logic [XLEN-1:0] pc;
    logic wb_valid_o;
    logic [4:0] wb_rd_o;
    logic [XLEN-1:0] wb_data_o;
    logic [XLEN-1:0] wb_pc_o;
    logic redirect_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic illegal_o;

    integer seed = 92;
    int cycles = 0;
    int mism_errs = 0;
    int other_errs = 0;
    logic [XLEN-1:0] regs [0:31];  // reference register file
    logic [XLEN-1:0] cur_pc;
    logic [XLEN-1:0] pend_tgt;
    logic drop_next;
    exp_t exp_q[$];
    exp_t head;
    logic head_ok;

    rv_pipe_top dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .stall_i       (stall),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_pc_o       (wb_pc_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .illegal_o     (illegal_o)
    );

    always #5 clk = ~clk;

    function automatic logic [XLEN-1:0] ref_alu(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (f3)
            3'd0: ref_alu = alt ? a - b : a + b;
            3'd1: ref_alu = a << b[5:0];
            3'd2: ref_alu = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: ref_alu = (a < b) ? 64'd1 : 64'd0;
            3'd4: ref_alu = a ^ b;
            3'd5: begin
                if (alt) ref_alu = $unsigned($signed(a) >>> b[5:0]);
                else ref_alu = a >> b[5:0];
            end
            3'd6: ref_alu = a | b;
            default: ref_alu = a & b;
        endcase
    endfunction

    function automatic logic br_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
        case (f3)
            3'b000: br_taken = (a == b);
            3'b001: br_taken = (a != b);
            3'b100: br_taken = ($signed(a) < $signed(b));
            3'b101: br_taken = ($signed(a) >= $signed(b));
            3'b110: br_taken = (a < b);
            default: br_taken = (a >= b);
        endcase
    endfunction

    task automatic refresh_head();
        head_ok = (exp_q.size() > 0);
        head    = head_ok ? exp_q[0] : '0;
    endtask

    // one random instruction, reference model and expected retirement
    task automatic next_instr();
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [12:0] bimm;
        logic [20:0] jimm;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [31:0] word;
        exp_t        e;
        int          kind;
        rs1   = 5'({$random(seed)} % 8);  // x0..x7, frequent dependences
        rs2   = 5'({$random(seed)} % 8);
        rd    = 5'({$random(seed)} % 8);
        f3    = 3'($random(seed));
        alt   = 1'($random(seed));
        imm12 = 12'($random(seed));
        imm20 = 20'($random(seed));
        kind  = {$random(seed)} % 10;
        a     = regs[rs1];
        b     = regs[rs2];
        e     = '0;
        e.pc  = cur_pc;
        e.rd  = rd;
        e.we  = 1'b1;
        case (kind)
            0, 1: begin
                alt    = alt && (f3 == 3'd0 || f3 == 3'd5);
                word   = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP};
                e.data = ref_alu(f3, alt, a, b);
            end
            2, 3: begin
                alt = alt && (f3 == 3'd5);
                if (f3 == 3'd1 || f3 == 3'd5) imm12 = {1'b0, alt, 4'b0, imm12[5:0]};
                word   = {imm12, rs1, f3, rd, OP_IMM};
                e.data = ref_alu(f3, alt, a, {{52{imm12[11]}}, imm12});
            end
            4: begin
                word   = {imm20, rd, LUI};
                e.data = {{32{imm20[19]}}, imm20, 12'b0};
            end
            5: begin
                word   = {imm20, rd, AUIPC};
                e.data = cur_pc + {{32{imm20[19]}}, imm20, 12'b0};
            end
            6: begin
                f3 = 3'({$random(seed)} % 6);
                if (f3 >= 3'd2) f3 = f3 + 3'd2;  // skip the two unused funct3 codes
                bimm    = {imm12, 1'b0};
                word    = {bimm[12], bimm[10:5], rs2, rs1, f3, bimm[4:1], bimm[11], BRANCH};
                e.we    = 1'b0;
                e.redir = br_taken(f3, a, b);
                e.tgt   = cur_pc + {{51{bimm[12]}}, bimm};
            end
            7: begin
                jimm    = {imm20, 1'b0};
                word    = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, JAL};
                e.data  = cur_pc + 64'd4;
                e.redir = 1'b1;
                e.tgt   = cur_pc + {{43{jimm[20]}}, jimm};
            end
            8: begin
                word    = {imm12, rs1, 3'b000, rd, JALR};
                e.data  = cur_pc + 64'd4;
                e.redir = 1'b1;
                e.tgt   = (a + {{52{imm12[11]}}, imm12}) & ~64'd1;
            end
            default: begin
                word  = {25'($random(seed)), 7'b0000011};  // load opcode, not supported
                e.rd  = word[11:7];
                e.we  = 1'b0;
                e.ill = 1'b1;
            end
        endcase
        instr       = word;
        pc          = cur_pc;
        instr_valid = 1'b1;
        if (drop_next) begin  // wrong-path slot behind a redirect
            drop_next = 1'b0;
            cur_pc    = pend_tgt;
        end else begin
            if (e.we && e.rd != 5'd0) regs[e.rd] = e.data;
            else e.data = '0;
            exp_q.push_back(e);
            refresh_head();
            drop_next = e.redir;
            pend_tgt  = e.tgt;
            cur_pc    = cur_pc + 64'd4;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && wb_valid_o && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_no_stray: assert property (@(posedge clk) disable iff (!rst_n) wb_valid_o |-> head_ok)
        else begin
            other_errs = other_errs + 1;
            $display("unexpected retirement at %0t with nothing outstanding", $time);
        end
    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n) stall |=> !wb_valid_o)
        else begin
            other_errs = other_errs + 1;
            $display("retirement during a stall at %0t", $time);
        end
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok) |-> wb_pc_o == head.pc)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: wb_pc_o %h, expected %h", $time,
                     $sampled(wb_pc_o), $sampled(head.pc));
        end
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok && head.we) |-> wb_rd_o == head.rd)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: wb_rd_o %0d, expected %0d", $time,
                     $sampled(wb_rd_o), $sampled(head.rd));
        end
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok) |-> wb_data_o == head.data)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: wb_data_o %h, expected %h", $time,
                     $sampled(wb_data_o), $sampled(head.data));
        end
    a_redir: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok) |-> redirect_o == head.redir)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: redirect_o %b, expected %b", $time,
                     $sampled(redirect_o), $sampled(head.redir));
        end
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok && head.redir) |-> redirect_pc_o == head.tgt)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: redirect_pc_o %h, expected %h", $time,
                     $sampled(redirect_pc_o), $sampled(head.tgt));
        end
    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid_o && head_ok) |-> illegal_o == head.ill)
        else begin
            mism_errs = mism_errs + 1;
            $display("Mismatch at %0t: illegal_o %b, expected %b", $time,
                     $sampled(illegal_o), $sampled(head.ill));
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: %0d retirements still missing after %0d cycles",
                     exp_q.size(), cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int stall_len;
        rst_n       = 1'b0;
        stall       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        cur_pc      = 64'h8000_0000;
        pend_tgt    = '0;
        drop_next   = 1'b0;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        refresh_head();
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            if ({$random(seed)} % 8 == 0) begin
                stall_len   = 1 + {$random(seed)} % 3;
                stall       = 1'b1;
                instr_valid = 1'b0;
                repeat (stall_len) begin
                    @(posedge clk);
                    #1;
                end
                stall = 1'b0;
            end
            next_instr();
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", mism_errs, other_errs);
        if (mism_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
